//--- Makefile
# Verilator build and run for the accumulator testbench

SRCS := $(wildcard hdl/*.sv include/*.svh dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcacc_tb: flist.f $(SRCS)
	verilator --binary --assert --top-module cacc_tb -f flist.f -Mdir obj_dir -o Vcacc_tb

run: obj_dir/Vcacc_tb
	./obj_dir/Vcacc_tb | tee sim.log
	grep -q '^Done: no errors$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/cacc_tb.sv
/* accumulator testbench
   table of register, beat and output rows applied in order against cacc_top */
`timescale 1ns/10ps
`include "cacc_config.svh"

module cacc_tb;

  localparam int TIMEOUT = 50;  // cycles per wait

  typedef enum {ROW_WRITE, ROW_READ, ROW_BEAT, ROW_OUT, ROW_INTR, ROW_QUIET} row_kind_e;

  typedef struct {
    row_kind_e               kind;
    logic [7:0]              addr;
    logic [31:0]             data;
    logic [63:0]             exp;       // read value or output lanes
    cacc_dp_pkg::abuf_addr_t mac_addr;
    logic                    first;
    logic                    last;
    cacc_dp_pkg::psum_vec_t  vec;
    int                      stall;     // max stall or quiet cycles
  } row_t;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        csb_req_valid;
  cacc_reg_pkg::req_op_e       csb_req_op;
  logic [7:0]                  csb_req_addr;
  logic [31:0]                 csb_req_wdata;
  logic                        mac_valid;
  cacc_dp_pkg::abuf_addr_t     mac_addr;
  logic                        mac_first;
  logic                        mac_last;
  cacc_dp_pkg::psum_vec_t      mac_data;
  logic                        sdp_ready;
  logic                        csb_req_ready;
  logic                        csb_resp_valid;
  logic [31:0]                 csb_resp_rdata;
  logic                        sdp_valid;
  cacc_dp_pkg::out_vec_t       sdp_data;
  logic                        credit_vld;
  logic                        done_intr;

  row_t rows[$];
  int   value_errs = 0;
  int   other_errs = 0;
  int   credit_cnt = 0;
  int   intr_cnt   = 0;
  int   pops       = 0;
  bit   aborted    = 1'b0;

  cacc_top dut0 (
    .nvdla_core_clk (clk),
    .rst_n          (rst_n),
    .csb_req_valid  (csb_req_valid),
    .csb_req_op     (csb_req_op),
    .csb_req_addr   (csb_req_addr),
    .csb_req_wdata  (csb_req_wdata),
    .mac_valid      (mac_valid),
    .mac_addr       (mac_addr),
    .mac_first      (mac_first),
    .mac_last       (mac_last),
    .mac_data       (mac_data),
    .sdp_ready      (sdp_ready),
    .csb_req_ready  (csb_req_ready),
    .csb_resp_valid (csb_resp_valid),
    .csb_resp_rdata (csb_resp_rdata),
    .sdp_valid      (sdp_valid),
    .sdp_data       (sdp_data),
    .credit_vld     (credit_vld),
    .done_intr      (done_intr)
  );

  always #50 clk = ~clk;  // 100 ns period

  // pulse counters sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && credit_vld)
      credit_cnt++;
    if (rst_n && done_intr)
      intr_cnt++;
  end

  // ==========================================================================
  // table building and expected values
  // ==========================================================================
  function automatic row_t blank_row(row_kind_e kind);
    row_t r;
    r.kind     = kind;
    r.addr     = '0;
    r.data     = '0;
    r.exp      = '0;
    r.mac_addr = '0;
    r.first    = 1'b0;
    r.last     = 1'b0;
    r.vec      = '0;
    r.stall    = 0;
    return r;
  endfunction

  function automatic logic [63:0] lanes4(int a, int b, int c, int d);
    return {16'(d), 16'(c), 16'(b), 16'(a)};  // lane 0 low
  endfunction

  // arithmetic shift, then clamp to the signed range of the mode
  function automatic logic [15:0] clamp_lane(int sum, int shift, bit int8);
    int s;
    int hi;
    int lo;
    s  = sum >>> shift;
    hi = int8 ? 127 : 32767;
    lo = int8 ? -128 : -32768;
    if (s > hi)
      s = hi;
    else if (s < lo)
      s = lo;
    return 16'(s);
  endfunction

  function automatic void write_row(logic [7:0] addr, int data);
    row_t r;
    r      = blank_row(ROW_WRITE);
    r.addr = addr;
    r.data = 32'(data);
    rows.push_back(r);  // write answers zero
  endfunction

  function automatic void read_row(logic [7:0] addr, int exp);
    row_t r;
    r      = blank_row(ROW_READ);
    r.addr = addr;
    r.exp  = 64'(32'(exp));
    rows.push_back(r);
  endfunction

  function automatic void beat_row(int addr, bit first, bit last, int a, int b, int c, int d);
    row_t r;
    r          = blank_row(ROW_BEAT);
    r.mac_addr = cacc_dp_pkg::abuf_addr_t'(addr);
    r.first    = first;
    r.last     = last;
    r.vec      = lanes4(a, b, c, d);
    rows.push_back(r);
  endfunction

  function automatic void output_row(int shift, bit int8, int a, int b, int c, int d,
                                     int max_stall);
    row_t r;
    r       = blank_row(ROW_OUT);
    r.exp   = {clamp_lane(d, shift, int8), clamp_lane(c, shift, int8),
               clamp_lane(b, shift, int8), clamp_lane(a, shift, int8)};
    r.stall = max_stall;
    rows.push_back(r);
  endfunction

  function automatic void intr_row();
    rows.push_back(blank_row(ROW_INTR));
  endfunction

  function automatic void quiet_row(int cycles);
    row_t r;
    r       = blank_row(ROW_QUIET);
    r.stall = cycles;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    // operation A in INT16 with truncate 2 and four outputs
    write_row(`CACC_REG_CFG, 32'h21);
    read_row(`CACC_REG_CFG, 32'h21);
    write_row(`CACC_REG_COUNT, 4);
    read_row(`CACC_REG_COUNT, 4);
    read_row(`CACC_REG_OP_EN, 0);
    read_row(`CACC_REG_STATUS, 0);
    write_row(`CACC_REG_OP_EN, 1);
    read_row(`CACC_REG_OP_EN, 1);
    beat_row(0, 1'b1, 1'b0, 10, 20, -30, 40);  // back-to-back on entry 0
    beat_row(0, 1'b0, 1'b0, 5, 5, 5, 5);
    beat_row(0, 1'b0, 1'b1, 1, 2, 3, 4);
    beat_row(1, 1'b1, 1'b0, 1000, -1000, 300, -7);  // entries 1 and 2 interleaved
    beat_row(2, 1'b1, 1'b0, -4000, 8, 12, 100);
    beat_row(1, 1'b0, 1'b0, 2000, -2000, -300, 7);
    beat_row(2, 1'b0, 1'b1, -4000, 8, 12, 100);
    beat_row(1, 1'b0, 1'b1, 1, 1, 1, 1);
    beat_row(3, 1'b1, 1'b1, 32767, -32768, 32767, -32768);
    output_row(2, 1'b0, 16, 27, -22, 49, 2);
    output_row(2, 1'b0, -8000, 16, 24, 200, 6);
    output_row(2, 1'b0, 3001, -2999, 1, 1, 3);
    output_row(2, 1'b0, 32767, -32768, 32767, -32768, 1);
    intr_row();
    read_row(`CACC_REG_STATUS, 1);
    read_row(`CACC_REG_OP_EN, 0);
    read_row(`CACC_REG_SAT, 0);
    beat_row(0, 1'b1, 1'b1, 5, 5, 5, 5);  // dropped while idle
    quiet_row(6);
    // operation B in INT8 with truncate 1 and two outputs
    write_row(`CACC_REG_CFG, 32'h10);
    read_row(`CACC_REG_CFG, 32'h10);
    write_row(`CACC_REG_COUNT, 2);
    write_row(`CACC_REG_OP_EN, 1);
    read_row(`CACC_REG_STATUS, 0);
    beat_row(5, 1'b1, 1'b0, 300, -300, 100, 20);
    beat_row(5, 1'b0, 1'b1, 100, -50, 50, 0);
    beat_row(6, 1'b1, 1'b1, 512, -1, 254, -256);
    output_row(1, 1'b1, 400, -350, 150, 20, 4);
    output_row(1, 1'b1, 512, -1, 254, -256, 2);
    intr_row();
    read_row(`CACC_REG_SAT, 3);  // two clamps, then one
    read_row(`CACC_REG_STATUS, 1);
    read_row(`CACC_REG_OP_EN, 0);
  endfunction

  // ==========================================================================
  // row tasks start and end 1 ns after a rising edge
  // ==========================================================================
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic reg_access(input row_t r);
    int n;
    n             = 0;
    csb_req_valid = 1'b1;
    csb_req_op    = (r.kind == ROW_WRITE) ? cacc_reg_pkg::REQ_WRITE : cacc_reg_pkg::REQ_READ;
    csb_req_addr  = r.addr;
    csb_req_wdata = r.data;
    @(negedge clk);
    while (!csb_req_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!csb_req_ready) begin
      other_errs++;
      aborted = 1'b1;
      $display("Timeout: register request to 0x%h was never accepted", r.addr);
      return;
    end
    @(posedge clk);
    #1;
    csb_req_valid = 1'b0;
    @(negedge clk);
    check_value("csb_resp_valid", 64'(csb_resp_valid), 64'(1'b1));
    check_value("csb_resp_rdata", 64'(csb_resp_rdata), r.exp);
    check_value("csb_req_ready", 64'(csb_req_ready), 64'(1'b0));  // busy while responding
    @(posedge clk);
    #1;
    @(negedge clk);
    check_value("csb_resp_valid", 64'(csb_resp_valid), 64'(1'b0));  // single response
    @(posedge clk);
    #1;
  endtask

  task automatic send_beat(input row_t r);
    mac_valid = 1'b1;
    mac_addr  = r.mac_addr;
    mac_first = r.first;
    mac_last  = r.last;
    mac_data  = r.vec;
    @(posedge clk);
    #1;
    mac_valid = 1'b0;
    mac_first = 1'b0;
    mac_last  = 1'b0;
  endtask

  task automatic take_output(input row_t r);
    int          n;
    int          stall;
    logic [63:0] held;
    n = 0;
    @(negedge clk);
    while (!sdp_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!sdp_valid) begin
      other_errs++;
      aborted = 1'b1;
      $display("Timeout: expected output never became valid");
      return;
    end
    check_value("sdp_data", sdp_data, r.exp);
    held  = sdp_data;
    stall = int'($urandom % 32'(r.stall + 1));
    repeat (stall) begin  // back-pressure
      @(negedge clk);
      check_value("sdp_valid", 64'(sdp_valid), 64'(1'b1));
      check_value("sdp_data", sdp_data, held);
    end
    @(posedge clk);
    #1;
    sdp_ready = 1'b1;
    @(negedge clk);
    check_value("credit_vld", 64'(credit_vld), 64'(1'b1));
    @(posedge clk);
    #1;
    sdp_ready = 1'b0;
    pops++;
  endtask

  task automatic wait_intr();
    int n;
    n = 0;
    @(negedge clk);
    while (!done_intr && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!done_intr) begin
      other_errs++;
      aborted = 1'b1;
      $display("Timeout: done interrupt never pulsed");
      return;
    end
    @(negedge clk);
    check_value("done_intr", 64'(done_intr), 64'(1'b0));  // one cycle wide
    @(posedge clk);
    #1;
  endtask

  task automatic watch_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (sdp_valid) begin
        other_errs++;
        $display("Output appeared although the operation was finished");
      end
    end
    @(posedge clk);
    #1;
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    rst_n         = 1'b0;
    csb_req_valid = 1'b0;
    csb_req_op    = cacc_reg_pkg::REQ_READ;
    csb_req_addr  = '0;
    csb_req_wdata = '0;
    mac_valid     = 1'b0;
    mac_addr      = '0;
    mac_first     = 1'b0;
    mac_last      = 1'b0;
    mac_data      = '0;
    sdp_ready     = 1'b0;
    void'($urandom(32'h8e69));
    build_table();

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("csb_resp_valid", 64'(csb_resp_valid), 64'(1'b0));
    check_value("sdp_valid", 64'(sdp_valid), 64'(1'b0));
    check_value("credit_vld", 64'(credit_vld), 64'(1'b0));
    check_value("done_intr", 64'(done_intr), 64'(1'b0));
    @(posedge clk);
    #1;

    for (int i = 0; i < rows.size() && !aborted; i++) begin
      case (rows[i].kind)
        ROW_WRITE, ROW_READ: reg_access(rows[i]);
        ROW_BEAT:            send_beat(rows[i]);
        ROW_OUT:             take_output(rows[i]);
        ROW_INTR:            wait_intr();
        default:             watch_quiet(rows[i].stall);
      endcase
    end

    if (!aborted) begin
      check_value("credit pulses", 64'(credit_cnt), 64'(pops));
      check_value("done_intr pulses", 64'(intr_cnt), 64'(2));
    end

    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0 && !aborted) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hdl/cacc_dp_pkg.sv
hdl/cacc_reg_pkg.sv
hdl/cacc_abuf_if.sv
hdl/cacc_regfile.sv
hdl/cacc_assembly_ctrl.sv
hdl/cacc_assembly_buffer.sv
hdl/cacc_calculator.sv
hdl/cacc_delivery_buffer.sv
hdl/cacc_delivery_ctrl.sv
hdl/cacc_top.sv
dv/cacc_tb.sv

//--- hdl/cacc_abuf_if.sv
/* assembly buffer port
   read by the assembly controller and written back by the calculator */
`timescale 1ns/10ps

interface cacc_abuf_if;

  logic                    rd_en;
  cacc_dp_pkg::abuf_addr_t rd_addr;
  cacc_dp_pkg::acc_vec_t   rd_data;  // valid one cycle after rd_en
  logic                    wr_en;
  cacc_dp_pkg::abuf_addr_t wr_addr;
  cacc_dp_pkg::acc_vec_t   wr_data;

  modport rd_side (output rd_en, output rd_addr, input rd_data);
  modport wr_side (output wr_en, output wr_addr, output wr_data, input rd_data);
  modport mem (input rd_en, input rd_addr, output rd_data,
               input wr_en, input wr_addr, input wr_data);

endinterface

//--- hdl/cacc_assembly_buffer.sv
/* assembly buffer
   running sums per entry with a registered read */
`timescale 1ns/10ps
`include "cacc_config.svh"

module cacc_assembly_buffer (
  input  logic      nvdla_core_clk,
  cacc_abuf_if.mem  abuf
);

  cacc_dp_pkg::acc_vec_t mem [`CACC_ABUF_DEPTH];

  always_ff @(posedge nvdla_core_clk) begin
    if (abuf.wr_en)
      mem[abuf.wr_addr] <= abuf.wr_data;
  end

  // returns old data on a same-address collision
  always_ff @(posedge nvdla_core_clk) begin
    if (abuf.rd_en)
      abuf.rd_data <= mem[abuf.rd_addr];
  end

endmodule

//--- hdl/cacc_assembly_ctrl.sv
/* assembly controller
   admits partial-sum beats, issues buffer reads and aligns control to rd_data */
`timescale 1ns/10ps

module cacc_assembly_ctrl (
  input  logic                      nvdla_core_clk,
  input  logic                      rst_n,
  input  cacc_reg_pkg::cfg_t        cfg,
  input  logic                      mac_valid,
  input  cacc_dp_pkg::abuf_addr_t   mac_addr,
  input  logic                      mac_first,
  input  logic                      mac_last,
  cacc_abuf_if.rd_side              abuf,
  output logic                      accu_valid,
  output cacc_dp_pkg::accu_ctrl_t   accu_ctrl
);

  logic admit;

  assign admit        = mac_valid && cfg.op_en;  // beats dropped while idle
  assign abuf.rd_en   = admit;
  assign abuf.rd_addr = mac_addr;

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n)
      accu_valid <= 1'b0;
    else
      accu_valid <= admit;
  end

  // lines up with rd_data from the buffer
  always_ff @(posedge nvdla_core_clk) begin
    if (admit) begin
      accu_ctrl.addr  <= mac_addr;
      accu_ctrl.first <= mac_first;
      accu_ctrl.last  <= mac_last;
    end
  end

endmodule

//--- hdl/cacc_calculator.sv
/* accumulator calculator
   adds beats to their entry, truncates and clamps finished entries for delivery */
`timescale 1ns/10ps
`include "cacc_config.svh"

module cacc_calculator (
  input  logic                         nvdla_core_clk,
  input  logic                         rst_n,
  input  cacc_reg_pkg::cfg_t           cfg,
  input  logic                         accu_valid,
  input  cacc_dp_pkg::accu_ctrl_t      accu_ctrl,
  input  cacc_dp_pkg::psum_vec_t       mac_data,
  cacc_abuf_if.wr_side                 abuf,
  output logic                         dlv_valid,
  output cacc_dp_pkg::out_vec_t        dlv_data,
  output logic [`CACC_REG_DATA_W-1:0]  sat_count
);

  localparam int LANES = `CACC_LANES;
  localparam int AW    = `CACC_ACC_W;
  localparam int PW    = `CACC_PSUM_W;
  localparam int OW    = `CACC_OUT_W;
  localparam int NW    = $clog2(LANES + 1);

  cacc_dp_pkg::psum_vec_t  mac_q;
  cacc_dp_pkg::acc_vec_t   base;
  cacc_dp_pkg::acc_vec_t   sum;
  cacc_dp_pkg::acc_vec_t   byp_data;
  cacc_dp_pkg::abuf_addr_t byp_addr;
  logic                    byp_valid;
  logic                    byp_hit;
  logic                    op_en_q;
  logic signed [AW-1:0]    shifted [LANES];
  logic signed [AW-1:0]    clamped [LANES];
  logic signed [AW-1:0]    sat_hi;
  logic signed [AW-1:0]    sat_lo;
  logic [NW-1:0]           nsat;

  // ==========================================================================
  // accumulate
  // ==========================================================================
  assign byp_hit = byp_valid && (byp_addr == accu_ctrl.addr);  // write still in flight
  assign sat_hi  = (cfg.precision == cacc_dp_pkg::PREC_INT8) ? AW'(127) : AW'(32767);
  assign sat_lo  = ~sat_hi;  // -128 or -32768

  always_comb begin
    nsat = '0;
    for (int i = 0; i < LANES; i++) begin
      if (accu_ctrl.first)
        base[i] = '0;
      else if (byp_hit)
        base[i] = byp_data[i];
      else
        base[i] = abuf.rd_data[i];
      sum[i]     = base[i] + {{(AW - PW){mac_q[i][PW-1]}}, mac_q[i]};
      shifted[i] = $signed(sum[i]) >>> cfg.truncate;
      if (shifted[i] > sat_hi)
        clamped[i] = sat_hi;
      else if (shifted[i] < sat_lo)
        clamped[i] = sat_lo;
      else
        clamped[i] = shifted[i];
      if (accu_valid && accu_ctrl.last && (clamped[i] != shifted[i]))
        nsat = nsat + NW'(1);
      dlv_data[i] = clamped[i][OW-1:0];  // INT8 stays sign-extended
    end
  end

  assign abuf.wr_en   = accu_valid;
  assign abuf.wr_addr = accu_ctrl.addr;
  assign abuf.wr_data = sum;
  assign dlv_valid    = accu_valid && accu_ctrl.last;

  // ==========================================================================
  // pipeline and saturation count
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk) begin
    mac_q    <= mac_data;  // aligns with accu_ctrl
    byp_addr <= abuf.wr_addr;
    byp_data <= abuf.wr_data;
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      byp_valid <= 1'b0;
      op_en_q   <= 1'b0;
      sat_count <= '0;
    end else begin
      byp_valid <= abuf.wr_en;
      op_en_q   <= cfg.op_en;
      if (cfg.op_en && !op_en_q)
        sat_count <= '0;  // new operation
      else
        sat_count <= sat_count + {{(`CACC_REG_DATA_W - NW){1'b0}}, nsat};
    end
  end

  // running sums must fit the accumulator width
  for (genvar g = 0; g < LANES; g++) begin : g_no_wrap
    a_acc_no_wrap: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
      (accu_valid && (base[g][AW-1] == mac_q[g][PW-1]))
        |-> (sum[g][AW-1] == base[g][AW-1]));
  end

endmodule

//--- hdl/cacc_delivery_buffer.sv
/* delivery FIFO toward the post-processor
   registered output stage, valid/ready back-pressure, one credit per pop */
`timescale 1ns/10ps
`include "cacc_config.svh"

module cacc_delivery_buffer (
  input  logic                   nvdla_core_clk,
  input  logic                   rst_n,
  input  logic                   dlv_valid,
  input  cacc_dp_pkg::out_vec_t  dlv_data,
  input  logic                   sdp_ready,
  output logic                   sdp_valid,
  output cacc_dp_pkg::out_vec_t  sdp_data,
  output logic                   credit_vld
);

  localparam int DEPTH = `CACC_DBUF_DEPTH;  // power of two so pointers wrap
  localparam int PTR_W = $clog2(DEPTH);

  cacc_dp_pkg::out_vec_t mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W:0]        count;
  logic                  pop;
  logic                  load;

  assign pop        = sdp_valid && sdp_ready;
  assign load       = (count != '0) && (!sdp_valid || sdp_ready);  // refill output stage
  assign credit_vld = pop;

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      sdp_valid <= 1'b0;
    end else begin
      if (dlv_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (load)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{PTR_W{1'b0}}, dlv_valid} - {{PTR_W{1'b0}}, load};
      if (load)
        sdp_valid <= 1'b1;
      else if (pop)
        sdp_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (dlv_valid)
      mem[wr_ptr] <= dlv_data;
    if (load)
      sdp_data <= mem[rd_ptr];
  end

  // credits at the source keep the calculator from overrunning the FIFO
  a_no_overflow: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    dlv_valid |-> (int'(count) < DEPTH));

  // entries held including the output stage never exceed the credits
  a_credit_bound: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    (int'(count) + int'(sdp_valid)) <= DEPTH);

endmodule

//--- hdl/cacc_delivery_ctrl.sv
/* delivery controller
   counts popped outputs and raises done at the programmed count */
`timescale 1ns/10ps

module cacc_delivery_ctrl (
  input  logic                nvdla_core_clk,
  input  logic                rst_n,
  input  cacc_reg_pkg::cfg_t  cfg,
  input  logic                credit_vld,
  output logic                done,
  output logic                done_intr
);

  logic [15:0] pop_cnt;

  assign done = cfg.op_en && credit_vld && ((pop_cnt + 16'd1) == cfg.dataout_count);

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n || !cfg.op_en)
      pop_cnt <= '0;  // idle between operations
    else if (credit_vld)
      pop_cnt <= pop_cnt + 16'd1;
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n)
      done_intr <= 1'b0;
    else
      done_intr <= done;  // one cycle after the final pop
  end

endmodule

//--- hdl/cacc_dp_pkg.sv
/* accumulator datapath types
   precision modes, lane vectors and the assembly control word */
`include "cacc_config.svh"

package cacc_dp_pkg;

  typedef enum logic {
    PREC_INT8  = 1'b0,
    PREC_INT16 = 1'b1
  } precision_e;

  // lane 0 in the low bits
  typedef logic [`CACC_LANES-1:0][`CACC_PSUM_W-1:0] psum_vec_t;
  typedef logic [`CACC_LANES-1:0][`CACC_ACC_W-1:0]  acc_vec_t;
  typedef logic [`CACC_LANES-1:0][`CACC_OUT_W-1:0]  out_vec_t;

  typedef logic [`CACC_ABUF_AW-1:0] abuf_addr_t;

  typedef struct packed {
    abuf_addr_t addr;
    logic       first;  // restart the entry
    logic       last;   // finish the entry and deliver
  } accu_ctrl_t;

endpackage

//--- hdl/cacc_reg_pkg.sv
/* accumulator register-side types
   request opcodes and the configuration word fanned out to all blocks */
`include "cacc_config.svh"

package cacc_reg_pkg;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  typedef struct packed {
    logic                    op_en;
    cacc_dp_pkg::precision_e precision;
    logic [3:0]              truncate;       // arithmetic right shift on last beat
    logic [15:0]             dataout_count;  // outputs until done
  } cfg_t;

endpackage

//--- hdl/cacc_regfile.sv
/* accumulator register file
   decodes the request channel and holds configuration and status */
`timescale 1ns/10ps
`include "cacc_config.svh"

module cacc_regfile (
  input  logic                         nvdla_core_clk,
  input  logic                         rst_n,
  input  logic                         csb_req_valid,
  input  cacc_reg_pkg::req_op_e        csb_req_op,
  input  logic [`CACC_REG_ADDR_W-1:0]  csb_req_addr,
  input  logic [`CACC_REG_DATA_W-1:0]  csb_req_wdata,
  input  logic                         done,
  input  logic [`CACC_REG_DATA_W-1:0]  sat_count,
  output logic                         csb_req_ready,
  output logic                         csb_resp_valid,
  output logic [`CACC_REG_DATA_W-1:0]  csb_resp_rdata,
  output cacc_reg_pkg::cfg_t           cfg
);

  logic                        req_take;
  logic                        wr_take;
  logic                        status_done;
  logic [`CACC_REG_DATA_W-1:0] rd_mux;

  assign csb_req_ready = !csb_resp_valid;  // one outstanding response
  assign req_take      = csb_req_valid && csb_req_ready;
  assign wr_take       = req_take && (csb_req_op == cacc_reg_pkg::REQ_WRITE);

  // ==========================================================================
  // read mux
  // ==========================================================================
  always_comb begin
    rd_mux = '0;
    case (csb_req_addr)
      `CACC_REG_OP_EN:  rd_mux[0] = cfg.op_en;
      `CACC_REG_CFG: begin
        rd_mux[0]   = cfg.precision;
        rd_mux[7:4] = cfg.truncate;
      end
      `CACC_REG_COUNT:  rd_mux[15:0] = cfg.dataout_count;
      `CACC_REG_STATUS: rd_mux[0] = status_done;
      `CACC_REG_SAT:    rd_mux = sat_count;
      default:          rd_mux = '0;  // unmapped reads as zero
    endcase
  end

  // ==========================================================================
  // write decode and response
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      cfg            <= '0;
      status_done    <= 1'b0;
      csb_resp_valid <= 1'b0;
      csb_resp_rdata <= '0;
    end else begin
      csb_resp_valid <= req_take;
      csb_resp_rdata <= wr_take ? '0 : rd_mux;  // writes answer zero
      if (wr_take) begin
        case (csb_req_addr)
          `CACC_REG_OP_EN: begin
            cfg.op_en <= csb_req_wdata[0];
            if (csb_req_wdata[0])
              status_done <= 1'b0;  // new operation
          end
          `CACC_REG_CFG: begin
            cfg.precision <= cacc_dp_pkg::precision_e'(csb_req_wdata[0]);
            cfg.truncate  <= csb_req_wdata[7:4];
          end
          `CACC_REG_COUNT: cfg.dataout_count <= csb_req_wdata[15:0];
          default: ;
        endcase
      end
      if (done) begin
        cfg.op_en   <= 1'b0;  // operation finished
        status_done <= 1'b1;
      end
    end
  end

  // a finished operation stays off until software starts the next one
  a_done_idle: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    status_done |-> !cfg.op_en);

endmodule

//--- hdl/cacc_top.sv
/* convolution accumulator top level
   register file, assembly and delivery stages on nvdla_core_clk */
`timescale 1ns/10ps
`include "cacc_config.svh"

module cacc_top (
  input  logic                         nvdla_core_clk,
  input  logic                         rst_n,
  input  logic                         csb_req_valid,
  input  cacc_reg_pkg::req_op_e        csb_req_op,
  input  logic [`CACC_REG_ADDR_W-1:0]  csb_req_addr,
  input  logic [`CACC_REG_DATA_W-1:0]  csb_req_wdata,
  input  logic                         mac_valid,
  input  cacc_dp_pkg::abuf_addr_t      mac_addr,
  input  logic                         mac_first,
  input  logic                         mac_last,
  input  cacc_dp_pkg::psum_vec_t       mac_data,
  input  logic                         sdp_ready,
  output logic                         csb_req_ready,
  output logic                         csb_resp_valid,
  output logic [`CACC_REG_DATA_W-1:0]  csb_resp_rdata,
  output logic                         sdp_valid,
  output cacc_dp_pkg::out_vec_t        sdp_data,
  output logic                         credit_vld,
  output logic                         done_intr
);

  cacc_reg_pkg::cfg_t          cfg;
  logic                        done;
  logic [`CACC_REG_DATA_W-1:0] sat_count;
  logic                        accu_valid;
  cacc_dp_pkg::accu_ctrl_t     accu_ctrl;
  logic                        dlv_valid;
  cacc_dp_pkg::out_vec_t       dlv_data;

  cacc_abuf_if abuf ();

  // ==========================================================================
  // register file
  // ==========================================================================
  cacc_regfile u_regfile (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .csb_req_valid  (csb_req_valid),
    .csb_req_op     (csb_req_op),
    .csb_req_addr   (csb_req_addr),
    .csb_req_wdata  (csb_req_wdata),
    .done           (done),
    .sat_count      (sat_count),
    .csb_req_ready  (csb_req_ready),
    .csb_resp_valid (csb_resp_valid),
    .csb_resp_rdata (csb_resp_rdata),
    .cfg            (cfg)
  );

  // ==========================================================================
  // assembly
  // ==========================================================================
  cacc_assembly_ctrl u_assembly_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .cfg            (cfg),
    .mac_valid      (mac_valid),
    .mac_addr       (mac_addr),
    .mac_first      (mac_first),
    .mac_last       (mac_last),
    .abuf           (abuf.rd_side),
    .accu_valid     (accu_valid),
    .accu_ctrl      (accu_ctrl)
  );

  cacc_assembly_buffer u_assembly_buffer (
    .nvdla_core_clk (nvdla_core_clk),
    .abuf           (abuf.mem)
  );

  cacc_calculator u_calculator (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .cfg            (cfg),
    .accu_valid     (accu_valid),
    .accu_ctrl      (accu_ctrl),
    .mac_data       (mac_data),
    .abuf           (abuf.wr_side),
    .dlv_valid      (dlv_valid),
    .dlv_data       (dlv_data),
    .sat_count      (sat_count)
  );

  // ==========================================================================
  // delivery
  // ==========================================================================
  cacc_delivery_buffer u_delivery_buffer (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .dlv_valid      (dlv_valid),
    .dlv_data       (dlv_data),
    .sdp_ready      (sdp_ready),
    .sdp_valid      (sdp_valid),
    .sdp_data       (sdp_data),
    .credit_vld     (credit_vld)
  );

  cacc_delivery_ctrl u_delivery_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .cfg            (cfg),
    .credit_vld     (credit_vld),
    .done           (done),
    .done_intr      (done_intr)
  );

endmodule

//--- include/cacc_config.svh
/* convolution accumulator build constants
   lane count, datapath widths, buffer depths and register map */
`ifndef CACC_CONFIG_SVH
`define CACC_CONFIG_SVH

// datapath
`define CACC_LANES       4   // output channels per beat
`define CACC_PSUM_W      16  // partial sum from the MAC array
`define CACC_ACC_W       24  // running sum
`define CACC_OUT_W       16  // lane toward the post-processor

// buffers
`define CACC_ABUF_DEPTH  8
`define CACC_ABUF_AW     $clog2(`CACC_ABUF_DEPTH)
`define CACC_DBUF_DEPTH  4   // also the credits held by the source at reset

// register channel
`define CACC_REG_ADDR_W  8
`define CACC_REG_DATA_W  32
`define CACC_REG_OP_EN   8'h00
`define CACC_REG_CFG     8'h01  // [0] precision, [7:4] truncate
`define CACC_REG_COUNT   8'h02  // [15:0] outputs per operation
`define CACC_REG_STATUS  8'h03  // [0] done
`define CACC_REG_SAT     8'h04  // clamped lane count

`endif
